//--- hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry of the direct-mapped store
    localparam int cache_index_bits = 7;
    localparam int cache_tag_bits = 32 - cache_index_bits - 2;
    localparam int cache_lines = 1 << cache_index_bits;

    typedef logic [cache_index_bits-1:0] cache_index_t;
    typedef logic [cache_tag_bits-1:0] cache_tag_t;

    // address split into tag, index and byte offset
    typedef struct packed {
        cache_tag_t   tag;
        cache_index_t index;
        logic [1:0]   offset;
    } cache_addr_fields_t;

    // same 32-bit address seen as a word or as fields
    typedef union packed {
        logic [31:0]        word;
        cache_addr_fields_t fields;
    } cache_addr_t;

    // one stored row
    typedef struct packed {
        logic [31:0] data;
        cache_tag_t  tag;
        logic        valid;
        logic        dirty;
    } cache_line_t;

    // pipeline request
    typedef struct packed {
        logic        valid;
        logic        wen;
        cache_addr_t addr;
        logic [31:0] wdata;
    } cpu_req_t;

    // memory request from the controller
    typedef struct packed {
        logic        valid;
        logic        wen;
        cache_addr_t addr;
        logic [31:0] wdata;
    } mem_req_t;

    // memory response, valid is a one-cycle pulse
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } mem_rsp_t;

    // single-cycle event pulses for the counters
    typedef struct packed {
        logic hit;
        logic miss;
        logic writeback;
    } cache_event_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [7:0] csr_ctrl_off = 8'h00;
    localparam logic [7:0] csr_hits_off = 8'h04;
    localparam logic [7:0] csr_misses_off = 8'h08;
    localparam logic [7:0] csr_wbacks_off = 8'h0C;

endpackage

`default_nettype wire

//--- hw/cache_line_store.sv
`default_nettype none

module cache_line_store (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::cache_index_t lookup_index,
    output cache_pkg::cache_line_t  lookup_line,
    input  logic                    wr_en,
    input  cache_pkg::cache_index_t wr_index,
    input  cache_pkg::cache_line_t  wr_line
);

    // payload arrays
    logic [31:0]           data_mem [cache_pkg::cache_lines];
    cache_pkg::cache_tag_t tag_mem  [cache_pkg::cache_lines];

    // per-line state bits, cleared on reset
    logic [cache_pkg::cache_lines-1:0] valid_bits;
    logic [cache_pkg::cache_lines-1:0] dirty_bits;

    // combinational lookup
    always_comb begin
        lookup_line.data  = data_mem[lookup_index];
        lookup_line.tag   = tag_mem[lookup_index];
        lookup_line.valid = valid_bits[lookup_index];
        lookup_line.dirty = dirty_bits[lookup_index];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_index] <= wr_line.data;
            tag_mem[wr_index]  <= wr_line.tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr_index] <= wr_line.valid;
            dirty_bits[wr_index] <= wr_line.dirty;
        end
    end

endmodule

`default_nettype wire

//--- hw/cache_controller.sv
`default_nettype none

module cache_controller (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  cache_pkg::cpu_req_t     cpu_req,
    output logic [31:0]             cpu_rdata,
    output logic                    cpu_stall,
    output cache_pkg::mem_req_t     mem_req,
    input  cache_pkg::mem_rsp_t     mem_rsp,
    output cache_pkg::cache_index_t lookup_index,
    input  cache_pkg::cache_line_t  lookup_line,
    output logic                    wr_en,
    output cache_pkg::cache_index_t wr_index,
    output cache_pkg::cache_line_t  wr_line,
    output cache_pkg::cache_event_t events
);

    typedef enum logic [2:0] {
        st_idle,
        st_wb,
        st_wb_wait,
        st_fill,
        st_fill_wait,
        st_unc_wait
    } state_t;

    state_t state_q;
    state_t state_d;

    logic                  hit;
    cache_pkg::cache_addr_t victim_addr;

    // request is held stable while stalled, so its index drives the store directly
    assign lookup_index = cpu_req.addr.fields.index;
    assign wr_index     = cpu_req.addr.fields.index;

    assign hit = lookup_line.valid && (lookup_line.tag == cpu_req.addr.fields.tag);

    // victim address rebuilt from the stored tag
    always_comb begin
        victim_addr.fields.tag    = lookup_line.tag;
        victim_addr.fields.index  = cpu_req.addr.fields.index;
        victim_addr.fields.offset = 2'b00;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        cpu_stall = 1'b0;
        cpu_rdata = lookup_line.data;
        mem_req   = '0;
        events    = '0;
        wr_en     = 1'b0;
        // default row is a store hit
        wr_line.data  = cpu_req.wdata;
        wr_line.tag   = cpu_req.addr.fields.tag;
        wr_line.valid = 1'b1;
        wr_line.dirty = 1'b1;

        case (state_q)
            st_idle: begin
                if (cpu_req.valid) begin
                    if (!enable) begin
                        // bypass the store entirely
                        cpu_stall = 1'b1;
                        state_d   = st_unc_wait;
                    end else if (hit) begin
                        events.hit = 1'b1;
                        wr_en      = cpu_req.wen;
                    end else begin
                        cpu_stall   = 1'b1;
                        events.miss = 1'b1;
                        if (lookup_line.valid && lookup_line.dirty) begin
                            state_d = st_wb;
                        end else begin
                            state_d = st_fill;
                        end
                    end
                end
            end

            st_wb, st_wb_wait: begin
                cpu_stall     = 1'b1;
                mem_req.valid = 1'b1;
                mem_req.wen   = 1'b1;
                mem_req.addr  = victim_addr;
                mem_req.wdata = lookup_line.data;
                if (mem_rsp.valid) begin
                    events.writeback = 1'b1;
                    state_d          = st_fill;
                end else begin
                    state_d = st_wb_wait;
                end
            end

            st_fill, st_fill_wait: begin
                cpu_stall     = 1'b1;
                mem_req.valid = 1'b1;
                mem_req.addr  = cpu_req.addr;
                if (mem_rsp.valid) begin
                    // clean line, the held request then hits in idle
                    wr_en         = 1'b1;
                    wr_line.data  = mem_rsp.rdata;
                    wr_line.dirty = 1'b0;
                    state_d       = st_idle;
                end else begin
                    state_d = st_fill_wait;
                end
            end

            st_unc_wait: begin
                mem_req.valid = 1'b1;
                mem_req.wen   = cpu_req.wen;
                mem_req.addr  = cpu_req.addr;
                mem_req.wdata = cpu_req.wdata;
                cpu_rdata     = mem_rsp.rdata;
                if (mem_rsp.valid) begin
                    state_d = st_idle;
                end else begin
                    cpu_stall = 1'b1;
                end
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cache_csr.sv
`default_nettype none

module cache_csr (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::apb_req_t     apb_req,
    output cache_pkg::apb_rsp_t     apb_rsp,
    output logic                    enable,
    input  cache_pkg::cache_event_t events
);

    // counter slots
    localparam int hit_cnt = 0;
    localparam int miss_cnt = 1;
    localparam int wback_cnt = 2;

    logic             access;
    logic             wr_access;
    logic             ctrl_sel;
    logic             mapped;
    logic             clear;
    logic [2:0]       event_vec;
    logic [2:0][31:0] counter_q;

    // access phase of an APB transfer
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign ctrl_sel  = (apb_req.paddr == cache_pkg::csr_ctrl_off);

    always_comb begin
        mapped = (apb_req.paddr == cache_pkg::csr_ctrl_off)
              || (apb_req.paddr == cache_pkg::csr_hits_off)
              || (apb_req.paddr == cache_pkg::csr_misses_off)
              || (apb_req.paddr == cache_pkg::csr_wbacks_off);
    end

    // bit1 of ctrl is a strobe and is never stored
    assign clear = wr_access && ctrl_sel && apb_req.pwdata[1];

    always_comb begin
        event_vec[hit_cnt]   = events.hit;
        event_vec[miss_cnt]  = events.miss;
        event_vec[wback_cnt] = events.writeback;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (wr_access && ctrl_sel) begin
            enable <= apb_req.pwdata[0];
        end
    end

    // clear takes priority over a same-cycle event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (clear) begin
                    counter_q[i] <= '0;
                end else if (event_vec[i]) begin
                    counter_q[i] <= counter_q[i] + 32'd1;
                end
            end
        end
    end

    // zero wait states
    always_comb begin
        apb_rsp.pready  = apb_req.psel;
        apb_rsp.pslverr = access && !mapped;
        case (apb_req.paddr)
            cache_pkg::csr_ctrl_off: begin
                apb_rsp.prdata = {31'b0, enable};
            end
            cache_pkg::csr_hits_off: begin
                apb_rsp.prdata = counter_q[hit_cnt];
            end
            cache_pkg::csr_misses_off: begin
                apb_rsp.prdata = counter_q[miss_cnt];
            end
            cache_pkg::csr_wbacks_off: begin
                apb_rsp.prdata = counter_q[wback_cnt];
            end
            default: begin
                apb_rsp.prdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cache_subsystem.sv
`default_nettype none

module cache_subsystem (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic [31:0]         cpu_rdata,
    output logic                cpu_stall,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp,
    input  cache_pkg::apb_req_t apb_req,
    output cache_pkg::apb_rsp_t apb_rsp
);

    logic                    enable;
    cache_pkg::cache_event_t events;
    cache_pkg::cache_index_t lookup_index;
    cache_pkg::cache_line_t  lookup_line;
    logic                    wr_en;
    cache_pkg::cache_index_t wr_index;
    cache_pkg::cache_line_t  wr_line;

    cache_line_store line_store0 (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .lookup_line  (lookup_line),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_line      (wr_line)
    );

    cache_controller controller0 (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .cpu_req      (cpu_req),
        .cpu_rdata    (cpu_rdata),
        .cpu_stall    (cpu_stall),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .lookup_index (lookup_index),
        .lookup_line  (lookup_line),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_line      (wr_line),
        .events       (events)
    );

    cache_csr csr0 (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .enable  (enable),
        .events  (events)
    );

endmodule

`default_nettype wire

//--- tb/cache_subsystem_assertions.sv
`default_nettype none

module cache_subsystem_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    cpu_stall,
    input cache_pkg::mem_req_t     mem_req,
    input cache_pkg::mem_rsp_t     mem_rsp,
    input cache_pkg::cache_event_t events
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failures = 0;

    // request held until memory answers
    assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_rsp.valid |=> mem_req.valid && $stable(mem_req))
    else begin
        failures++;
        $error("memory request changed before its response");
    end

    assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_rsp.valid |-> cpu_stall)
    else begin
        failures++;
        $error("stall low while a memory request is pending");
    end

    // a miss starts a memory request in the next cycle
    assert property (@(posedge clk) disable iff (rst)
        events.miss |=> mem_req.valid && cpu_stall)
    else begin
        failures++;
        $error("no memory request in the cycle after a miss");
    end

endmodule

bind cache_controller cache_subsystem_assertions assertions0 (
    .clk       (clk),
    .rst       (rst),
    .cpu_stall (cpu_stall),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .events    (events)
);

`default_nettype wire

//--- tb/cache_subsystem_tb.sv
`default_nettype none

module cache_subsystem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 200;

    logic                clk;
    logic                rst;
    cache_pkg::cpu_req_t cpu_req;
    logic [31:0]         cpu_rdata;
    logic                cpu_stall;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp;
    cache_pkg::apb_req_t apb_req;
    cache_pkg::apb_rsp_t apb_rsp;

    // backing memory, architectural model and shadow directory
    logic [31:0]                       mem_words [logic [31:0]];
    logic [31:0]                       model_mem [logic [31:0]];
    cache_pkg::cache_tag_t             shadow_tag [cache_pkg::cache_lines];
    logic [cache_pkg::cache_lines-1:0] shadow_valid;
    logic [cache_pkg::cache_lines-1:0] shadow_dirty;
    cache_pkg::mem_req_t               exp_mem_q [$];

    int          errors = 0;
    int          timeouts = 0;
    int unsigned exp_hits = 0;
    int unsigned exp_misses = 0;
    int unsigned exp_wbacks = 0;
    logic        cached = 1'b0;

    cache_subsystem dut0 (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rdata (cpu_rdata),
        .cpu_stall (cpu_stall),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // unwritten words read as a hash of the whole address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        return model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
    endfunction

    // word aligned within 4 KB, eight tags per index
    function automatic logic [31:0] random_addr();
        return $urandom() & 32'h0000_0ffc;
    endfunction

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                               input logic [31:0] addr);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: load from %h returned %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_mem_req(input cache_pkg::mem_req_t got, input cache_pkg::mem_req_t exp);
        if (got.wen !== exp.wen || got.addr.word !== exp.addr.word
                || (exp.wen && got.wdata !== exp.wdata)) begin
            errors++;
            $display("error at %0t: memory request wen %b addr %h data %h, expected %b %h %h",
                     $time, got.wen, got.addr.word, got.wdata, exp.wen, exp.addr.word, exp.wdata);
        end
    endtask

    task automatic check_csr(input string name, input cache_pkg::apb_rsp_t got,
                             input logic [31:0] exp, input logic exp_err);
        if (got.pslverr !== exp_err || (!exp_err && got.prdata !== exp)) begin
            errors++;
            $display("error at %0t: %s read %h pslverr %b, expected %h pslverr %b",
                     $time, name, got.prdata, got.pslverr, exp, exp_err);
        end
    endtask

    // setup phase, then access phase until pready
    task automatic apb_xfer(input logic write, input logic [7:0] off, input logic [31:0] wdata,
                            output cache_pkg::apb_rsp_t rsp);
        cache_pkg::apb_req_t req;
        int                  cycles;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: off, pwdata: wdata};
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!apb_rsp.pready && cycles < wait_limit);
        rsp = apb_rsp;
        apb_req <= '0;
        if (!rsp.pready) begin
            timeouts++;
            $display("timeout: APB access to offset %h never saw pready", off);
        end
    endtask

    task automatic read_csr(input logic [7:0] off, input string name,
                            input logic [31:0] exp, input logic exp_err);
        cache_pkg::apb_rsp_t rsp;
        apb_xfer(1'b0, off, 32'd0, rsp);
        check_csr(name, rsp, exp, exp_err);
    endtask

    task automatic check_counters(input logic [31:0] hits, input logic [31:0] misses,
                                  input logic [31:0] wbacks);
        read_csr(cache_pkg::csr_hits_off, "hit counter", hits, 1'b0);
        read_csr(cache_pkg::csr_misses_off, "miss counter", misses, 1'b0);
        read_csr(cache_pkg::csr_wbacks_off, "write-back counter", wbacks, 1'b0);
    endtask

    // predict memory traffic, issue one request and wait for stall to drop
    task automatic access(input logic wen, input logic [31:0] addr, input logic [31:0] wdata);
        cache_pkg::cpu_req_t     req;
        cache_pkg::mem_req_t     exp;
        cache_pkg::cache_addr_t  victim;
        cache_pkg::cache_index_t idx;
        logic [31:0]             expected;
        logic                    stall_free;
        int                      cycles;
        req = '{valid: 1'b1, wen: wen, addr: addr, wdata: wdata};
        idx = req.addr.fields.index;
        expected = model_read(addr);
        if (!cached) begin
            exp = '{valid: 1'b1, wen: wen, addr: addr, wdata: wdata};
            exp_mem_q.push_back(exp);
        end else begin
            if (!shadow_valid[idx] || shadow_tag[idx] != req.addr.fields.tag) begin
                exp_misses++;
                if (shadow_valid[idx] && shadow_dirty[idx]) begin
                    victim.fields.tag = shadow_tag[idx];
                    victim.fields.index = idx;
                    victim.fields.offset = 2'b00;
                    exp = '{valid: 1'b1, wen: 1'b1, addr: victim, wdata: model_read(victim.word)};
                    exp_mem_q.push_back(exp);
                    exp_wbacks++;
                end
                exp = '{valid: 1'b1, wen: 1'b0, addr: addr, wdata: 32'd0};
                exp_mem_q.push_back(exp);
                shadow_tag[idx] = req.addr.fields.tag;
                shadow_valid[idx] = 1'b1;
                shadow_dirty[idx] = 1'b0;
            end
            // a filled line lets the held request finish as a hit
            exp_hits++;
            shadow_dirty[idx] = shadow_dirty[idx] | wen;
        end
        // no memory traffic means a hit with no stall cycle
        stall_free = (exp_mem_q.size() == 0);
        if (wen) begin
            model_mem[addr] = wdata;
        end
        @(posedge clk);
        cpu_req <= req;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cpu_stall && cycles < wait_limit);
        cpu_req <= '0;
        if (cpu_stall) begin
            timeouts++;
            $display("timeout: access to %h still stalled after %0d cycles", addr, cycles);
        end else begin
            if (stall_free && cycles != 1) begin
                errors++;
                $display("error at %0t: hit on %h stalled for %0d cycles",
                         $time, addr, cycles - 1);
            end
            if (!wen) begin
                check_rdata(cpu_rdata, expected, addr);
            end
        end
        if (exp_mem_q.size() != 0) begin
            errors++;
            $display("error at %0t: access to %h left %0d memory requests unissued",
                     $time, addr, exp_mem_q.size());
            exp_mem_q.delete();
        end
    endtask

    // memory responder, 1 to 4 cycles of latency
    initial begin
        int   delay;
        logic pending;
        delay = 0;
        pending = 1'b0;
        mem_rsp <= '0;
        forever begin
            @(posedge clk);
            if (mem_rsp.valid) begin
                mem_rsp <= '0;
                pending = 1'b0;
            end else if (mem_req.valid) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay = $urandom_range(3, 0);
                    if (exp_mem_q.size() == 0) begin
                        errors++;
                        $display("error at %0t: unexpected memory request to %h",
                                 $time, mem_req.addr.word);
                    end else begin
                        check_mem_req(mem_req, exp_mem_q.pop_front());
                    end
                end
                if (delay == 0) begin
                    if (mem_req.wen) begin
                        mem_words[mem_req.addr.word] = mem_req.wdata;
                    end
                    mem_rsp <= '{valid: 1'b1, rdata: mem_read(mem_req.addr.word)};
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        cache_pkg::apb_rsp_t rsp;
        int unsigned         assert_fails;
        void'($urandom(2));
        rst <= 1'b1;
        cpu_req <= '0;
        apb_req <= '0;
        shadow_valid = '0;
        shadow_dirty = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        read_csr(cache_pkg::csr_ctrl_off, "ctrl", 32'd0, 1'b0);
        check_counters(32'd0, 32'd0, 32'd0);
        read_csr(8'h10, "unmapped offset", 32'd0, 1'b1);

        // uncached traffic only before the first cached access
        repeat (40) begin
            access(1'($urandom_range(1, 0)), random_addr(), $urandom());
        end
        check_counters(32'd0, 32'd0, 32'd0);

        apb_xfer(1'b1, cache_pkg::csr_ctrl_off, 32'd1, rsp);
        cached = 1'b1;
        repeat (400) begin
            access(1'($urandom_range(1, 0)), random_addr(), $urandom());
        end
        check_counters(exp_hits, exp_misses, exp_wbacks);

        // clear strobe with enable kept set
        apb_xfer(1'b1, cache_pkg::csr_ctrl_off, 32'd3, rsp);
        check_counters(32'd0, 32'd0, 32'd0);
        read_csr(cache_pkg::csr_ctrl_off, "ctrl", 32'd1, 1'b0);

        assert_fails = dut0.controller0.assertions0.failures;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_subsystem.f
hw/cache_pkg.sv
hw/cache_line_store.sv
hw/cache_controller.sv
hw/cache_csr.sv
hw/cache_subsystem.sv
tb/cache_subsystem_assertions.sv
tb/cache_subsystem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f cache_subsystem.f --top-module cache_subsystem_tb -o sim_cache

out=$(./obj_dir/sim_cache +verilator+error+limit+100) || true
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "^TESTS PASSED$"
